// ==== hw/cgra.sv ====
`timescale 1ns/1ps

module cgra #(
    parameter int CONTEXTS  = 8,
    parameter int MEM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  conf_wr_en,
    input  cgra_pkg::ctx_t        conf_wr_addr,
    input  isa_pkg::array_inst_t  conf_wr_data,
    input  logic                  conf_rd_en,
    input  cgra_pkg::ctx_t        conf_rd_addr,
    output cgra_pkg::pe_results_t pe_results
);

    import cgra_pkg::*;
    import isa_pkg::*;

    array_inst_t active;
    word_t       results  [NUM_ROWS][NUM_COLS];
    word_t       lsu_data [NUM_ROWS];

    config_store #(
        .CONTEXTS (CONTEXTS)
    ) i_config_store (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (conf_wr_en),
        .wr_addr (conf_wr_addr),
        .wr_data (conf_wr_data),
        .rd_en   (conf_rd_en),
        .rd_addr (conf_rd_addr),
        .active  (active)
    );

    ////////////////////////////////////////
    // Rows: LSU, bank and PE torus
    ////////////////////////////////////////

    for (genvar gr = 0; gr < NUM_ROWS; gr++) begin : g_row
        localparam int R_UP   = (gr + NUM_ROWS - 1) % NUM_ROWS;
        localparam int R_DOWN = (gr + 1) % NUM_ROWS;

        word_t [NUM_COLS-1:0] row_words;
        logic                 wr_en;
        addr_t                wr_addr;
        word_t                wr_data;
        addr_t                rd_addr;
        word_t                rd_data;

        always_comb begin
            for (int c = 0; c < NUM_COLS; c++) begin
                row_words[c] = results[gr][c];
            end
        end

        lsu i_lsu (
            .row_results (row_words),
            .inst        (active[gr].lsu),
            .rd_data     (rd_data),
            .wr_en       (wr_en),
            .wr_addr     (wr_addr),
            .wr_data     (wr_data),
            .rd_addr     (rd_addr),
            .lsu_data    (lsu_data[gr])
        );

        mem_bank #(
            .MEM_WORDS (MEM_WORDS)
        ) i_mem_bank (
            .clk     (clk),
            .wr_en   (wr_en),
            .wr_addr (wr_addr),
            .wr_data (wr_data),
            .rd_addr (rd_addr),
            .rd_data (rd_data)
        );

        for (genvar gc = 0; gc < NUM_COLS; gc++) begin : g_col
            localparam int C_LEFT  = (gc + NUM_COLS - 1) % NUM_COLS;
            localparam int C_RIGHT = (gc + 1) % NUM_COLS;

            // Neighbors wrap at both edges
            pe i_pe (
                .clk      (clk),
                .reset    (reset),
                .inst     (active[gr].pe[gc]),
                .up       (results[R_UP][gc]),
                .down     (results[R_DOWN][gc]),
                .left     (results[gr][C_LEFT]),
                .right    (results[gr][C_RIGHT]),
                .lsu_data (lsu_data[gr]),
                .result   (results[gr][gc])
            );
        end
    end

    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                pe_results[r*NUM_COLS+c] = results[r][c];
            end
        end
    end

endmodule

// ==== hw/cgra_pkg.sv ====
package cgra_pkg;

    // Array geometry
    localparam int NUM_ROWS = 4;
    localparam int NUM_COLS = 4;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 14;
    localparam int CTX_W  = 3;
    localparam int COL_W  = $clog2(NUM_COLS);

    typedef logic [WORD_W-1:0] word_t;

    // Bank word address
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [CTX_W-1:0] ctx_t;
    typedef logic [COL_W-1:0] col_t;

    // All PE results in row-major order
    typedef word_t [NUM_ROWS*NUM_COLS-1:0] pe_results_t;

endpackage

// ==== hw/config_store.sv ====
`timescale 1ns/1ps

module config_store #(
    parameter int CONTEXTS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  cgra_pkg::ctx_t       wr_addr,
    input  isa_pkg::array_inst_t wr_data,
    input  logic                 rd_en,
    input  cgra_pkg::ctx_t       rd_addr,
    output isa_pkg::array_inst_t active
);

    import isa_pkg::*;

    array_inst_t ctx_mem [CONTEXTS];

    ////////////////////////////////////////
    // Context memory
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ctx_mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Active instruction register
    ////////////////////////////////////////

    // All-zero encodes NOP on every PE and NONE on every LSU
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= '0;
        end else if (rd_en) begin
            // Old contents if the same context is written this cycle
            active <= ctx_mem[rd_addr];
        end
    end

endmodule

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    import cgra_pkg::*;

    ////////////////////////////////////////
    // PE instruction
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        PE_NOP  = 4'd0,
        PE_PASS = 4'd1,
        PE_ADD  = 4'd2,
        PE_SUB  = 4'd3,
        PE_AND  = 4'd4,
        PE_OR   = 4'd5,
        PE_XOR  = 4'd6
    } pe_op_e;

    // Operand source
    typedef enum logic [2:0] {
        SRC_UP    = 3'd0,
        SRC_DOWN  = 3'd1,
        SRC_LEFT  = 3'd2,
        SRC_RIGHT = 3'd3,
        SRC_SELF  = 3'd4,
        SRC_LSU   = 3'd5,
        SRC_IMM   = 3'd6,
        SRC_ZERO  = 3'd7
    } src_sel_e;

    typedef struct packed {
        pe_op_e      op;
        src_sel_e    src_a;
        src_sel_e    src_b;
        logic [15:0] imm;
        logic [5:0]  spare;
    } pe_inst_t;

    ////////////////////////////////////////
    // LSU instruction
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        LSU_NONE  = 2'd0,
        LSU_LOAD  = 2'd1,
        LSU_STORE = 2'd2
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e op;
        col_t    data_sel;
        logic    index_en;
        col_t    index_sel;
        addr_t   base;
    } lsu_inst_t;

    typedef struct packed {
        pe_inst_t [NUM_COLS-1:0] pe;
        lsu_inst_t               lsu;
    } row_inst_t;

    // One full context
    typedef row_inst_t [NUM_ROWS-1:0] array_inst_t;

endpackage

// ==== hw/lsu.sv ====
`timescale 1ns/1ps

module lsu (
    input  cgra_pkg::word_t [cgra_pkg::NUM_COLS-1:0] row_results,
    input  isa_pkg::lsu_inst_t                       inst,
    input  cgra_pkg::word_t                          rd_data,
    output logic                                     wr_en,
    output cgra_pkg::addr_t                          wr_addr,
    output cgra_pkg::word_t                          wr_data,
    output cgra_pkg::addr_t                          rd_addr,
    output cgra_pkg::word_t                          lsu_data
);

    import cgra_pkg::*;
    import isa_pkg::*;

    addr_t index;
    addr_t eff_addr;

    // Low address bits of the index PE
    assign index = inst.index_en ? addr_t'(row_results[inst.index_sel]) : '0;

    // Wraps within the address width
    assign eff_addr = inst.base + index;

    ////////////////////////////////////////
    // Bank side
    ////////////////////////////////////////

    assign wr_en   = (inst.op == LSU_STORE);
    assign wr_addr = eff_addr;
    assign wr_data = row_results[inst.data_sel];
    assign rd_addr = eff_addr;

    // Bank read data is registered one cycle after the address
    assign lsu_data = rd_data;

endmodule

// ==== hw/mem_bank.sv ====
`timescale 1ns/1ps

module mem_bank #(
    parameter int MEM_WORDS = 1024
) (
    input  logic            clk,
    input  logic            wr_en,
    input  cgra_pkg::addr_t wr_addr,
    input  cgra_pkg::word_t wr_data,
    input  cgra_pkg::addr_t rd_addr,
    output cgra_pkg::word_t rd_data
);

    import cgra_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Only the low address bits select a word
    assign wr_idx = wr_addr[IDX_W-1:0];
    assign rd_idx = rd_addr[IDX_W-1:0];

    // Read during write to the same word returns the old word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx];
    end

endmodule

// ==== hw/pe.sv ====
`timescale 1ns/1ps

module pe (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::pe_inst_t inst,
    input  cgra_pkg::word_t   up,
    input  cgra_pkg::word_t   down,
    input  cgra_pkg::word_t   left,
    input  cgra_pkg::word_t   right,
    input  cgra_pkg::word_t   lsu_data,
    output cgra_pkg::word_t   result
);

    import cgra_pkg::*;
    import isa_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_out;

    function automatic word_t operand(input src_sel_e sel);
        word_t val;
        case (sel)
            SRC_UP:    val = up;
            SRC_DOWN:  val = down;
            SRC_LEFT:  val = left;
            SRC_RIGHT: val = right;
            SRC_SELF:  val = result;
            SRC_LSU:   val = lsu_data;
            SRC_IMM:   val = word_t'(inst.imm);
            default:   val = '0;
        endcase
        return val;
    endfunction

    always_comb begin
        op_a = operand(inst.src_a);
        op_b = operand(inst.src_b);
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        // NOP and unused codes hold
        alu_out = result;
        case (inst.op)
            PE_PASS: alu_out = op_a;
            PE_ADD:  alu_out = op_a + op_b;
            PE_SUB:  alu_out = op_a - op_b;
            PE_AND:  alu_out = op_a & op_b;
            PE_OR:   alu_out = op_a | op_b;
            PE_XOR:  alu_out = op_a ^ op_b;
            default: alu_out = result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= alu_out;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tb_cgra -o tb_cgra_sim --Mdir obj_dir

# A failed check ends the run with a non-zero status, the log decides
./obj_dir/tb_cgra_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation passed"

// ==== tb.f ====
hw/cgra_pkg.sv
hw/isa_pkg.sv
hw/config_store.sv
hw/pe.sv
hw/lsu.sv
hw/mem_bank.sv
hw/cgra.sv
tests/cgra_asserts.sv
tests/tb_cgra.sv

// ==== tests/cgra_asserts.sv ====
`timescale 1ns/1ps

module cgra_asserts (
    input logic                          clk,
    input logic                          reset,
    input logic                          conf_wr_en,
    input logic                          conf_rd_en,
    input isa_pkg::array_inst_t          active,
    input logic [cgra_pkg::NUM_ROWS-1:0] bank_wr_en
);

    import cgra_pkg::*;
    import isa_pkg::*;

    // All-zero is NOP on every PE and NONE on every LSU
    assert property (@(posedge clk) reset |=> active == '0)
        else $error("active context not idle during or right after reset");

    assert property (@(posedge clk) disable iff (reset) !$isunknown({conf_wr_en, conf_rd_en}))
        else $error("configuration strobe is unknown");

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
        assert property (@(posedge clk) disable iff (reset)
            bank_wr_en[r] |-> active[r].lsu.op != LSU_NONE)
            else $error("bank %0d written while its LSU is idle", r);
    end

endmodule

bind cgra cgra_asserts i_cgra_asserts (
    .clk        (clk),
    .reset      (reset),
    .conf_wr_en (conf_wr_en),
    .conf_rd_en (conf_rd_en),
    .active     (active),
    .bank_wr_en ({g_row[3].wr_en, g_row[2].wr_en, g_row[1].wr_en, g_row[0].wr_en})
);

// ==== tests/tb_cgra.sv ====
`timescale 1ns/1ps

module tb_cgra;

    import cgra_pkg::*;
    import isa_pkg::*;

    localparam int NUM_PE = NUM_ROWS * NUM_COLS;

    logic        clk = 1'b0;
    logic        reset;
    logic        conf_wr_en;
    ctx_t        conf_wr_addr;
    array_inst_t conf_wr_data;
    logic        conf_rd_en;
    ctx_t        conf_rd_addr;
    pe_results_t pe_results;

    logic [31:0] lfsr_state = 32'h4028_4d94;
    array_inst_t ctx_data;
    word_t       expected [NUM_PE];
    word_t       init_val [NUM_PE];
    logic [15:0] imm_val  [NUM_PE];

    cgra i_cgra (
        .clk          (clk),
        .reset        (reset),
        .conf_wr_en   (conf_wr_en),
        .conf_wr_addr (conf_wr_addr),
        .conf_wr_data (conf_wr_data),
        .conf_rd_en   (conf_rd_en),
        .conf_rd_addr (conf_rd_addr),
        .pe_results   (pe_results)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Stimulus and reference helpers
    ////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int n = 0; n < nbits; n++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] bits;
        bits = lfsr_take(16);
        return bits[15:0];
    endfunction

    function automatic pe_inst_t make_pe_inst(input pe_op_e op, input src_sel_e src_a,
                                              input src_sel_e src_b, input logic [15:0] imm);
        pe_inst_t inst;
        inst.op    = op;
        inst.src_a = src_a;
        inst.src_b = src_b;
        inst.imm   = imm;
        inst.spare = '0;
        return inst;
    endfunction

    function automatic lsu_inst_t make_lsu_inst(input lsu_op_e op, input col_t data_sel,
                                                input logic index_en, input col_t index_sel,
                                                input addr_t base);
        lsu_inst_t inst;
        inst.op        = op;
        inst.data_sel  = data_sel;
        inst.index_en  = index_en;
        inst.index_sel = index_sel;
        inst.base      = base;
        return inst;
    endfunction

    // Expected ALU result for each op
    function automatic word_t apply_op(input pe_op_e op, input word_t a, input word_t b);
        case (op)
            PE_ADD:  return a + b;
            PE_SUB:  return a - b;
            PE_AND:  return a & b;
            PE_OR:   return a | b;
            PE_XOR:  return a ^ b;
            default: return a;
        endcase
    endfunction

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_results(input string tag);
        for (int i = 0; i < NUM_PE; i++) begin
            compare_value($sformatf("%s pe_results[%0d]", tag, i), pe_results[i], expected[i]);
        end
    endtask

    // Same op and source on every PE with fresh immediates and idle LSUs
    task automatic fill_context(input pe_op_e op, input src_sel_e src_a);
        for (int i = 0; i < NUM_PE; i++) begin
            imm_val[i] = rand_imm();
            ctx_data[i / NUM_COLS].pe[i % NUM_COLS] = make_pe_inst(op, src_a, SRC_IMM, imm_val[i]);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            ctx_data[r].lsu = make_lsu_inst(LSU_NONE, 2'd0, 1'b0, 2'd0, '0);
        end
    endtask

    // Both strobes start right after a falling edge
    task automatic write_context(input ctx_t ctx);
        conf_wr_en   = 1'b1;
        conf_wr_addr = ctx;
        conf_wr_data = ctx_data;
        @(negedge clk);
        conf_wr_en = 1'b0;
    endtask

    task automatic activate_context(input ctx_t ctx);
        conf_rd_en   = 1'b1;
        conf_rd_addr = ctx;
        @(negedge clk);
        conf_rd_en = 1'b0;
    endtask

    task automatic preload_values();
        activate_context(3'd1);
        @(negedge clk);
        expected = init_val;
        check_results("preload");
    endtask

    // Called in cycle t+1 of the strobe with k = 0
    task automatic check_rotation(input string tag, input logic by_row);
        int r;
        int c;
        int src;
        for (int k = 0; k <= 4; k++) begin
            for (int i = 0; i < NUM_PE; i++) begin
                r = i / NUM_COLS;
                c = i % NUM_COLS;
                if (by_row) begin
                    src = ((r - k + NUM_ROWS) % NUM_ROWS) * NUM_COLS + c;
                end else begin
                    src = r * NUM_COLS + (c - k + NUM_COLS) % NUM_COLS;
                end
                expected[i] = init_val[src];
            end
            check_results($sformatf("%s k=%0d", tag, k));
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_idle();
        for (int i = 0; i < NUM_PE; i++) begin
            expected[i] = '0;
        end
        repeat (5) begin
            check_results("idle");
            @(negedge clk);
        end
    endtask

    task automatic test_contexts();
        fill_context(PE_PASS, SRC_IMM);
        write_context(3'd0);
        for (int i = 0; i < NUM_PE; i++) begin
            init_val[i] = word_t'(imm_val[i]);
        end
        fill_context(PE_PASS, SRC_IMM);
        write_context(3'd5);
        activate_context(3'd0);
        // Cycle t+1 still shows the idle array
        check_results("ctx0 t+1");
        @(negedge clk);
        expected = init_val;
        check_results("ctx0 t+2");
        activate_context(3'd5);
        @(negedge clk);
        for (int i = 0; i < NUM_PE; i++) begin
            expected[i] = word_t'(imm_val[i]);
        end
        check_results("ctx5");
        fill_context(PE_PASS, SRC_IMM);
        write_context(3'd5);
        repeat (3) begin
            check_results("ctx5 rewritten");
            @(negedge clk);
        end
    endtask

    task automatic test_rotation();
        fill_context(PE_PASS, SRC_IMM);
        write_context(3'd1);
        for (int i = 0; i < NUM_PE; i++) begin
            init_val[i] = word_t'(imm_val[i]);
        end
        fill_context(PE_PASS, SRC_LEFT);
        write_context(3'd2);
        fill_context(PE_PASS, SRC_UP);
        write_context(3'd3);
        preload_values();
        activate_context(3'd2);
        check_rotation("left", 1'b0);
        preload_values();
        activate_context(3'd3);
        check_rotation("up", 1'b1);
    endtask

    // Starts from the context 1 values loaded by test_rotation
    task automatic test_alu();
        pe_op_e ops [NUM_PE];
        fill_context(PE_ADD, SRC_SELF);
        for (int i = 0; i < NUM_PE; i++) begin
            case (i % 5)
                0:       ops[i] = PE_ADD;
                1:       ops[i] = PE_SUB;
                2:       ops[i] = PE_AND;
                3:       ops[i] = PE_OR;
                default: ops[i] = PE_XOR;
            endcase
            ctx_data[i / NUM_COLS].pe[i % NUM_COLS].op = ops[i];
        end
        write_context(3'd4);
        preload_values();
        activate_context(3'd4);
        check_results("alu start");
        for (int n = 1; n <= 6; n++) begin
            @(negedge clk);
            for (int i = 0; i < NUM_PE; i++) begin
                expected[i] = apply_op(ops[i], expected[i], word_t'(imm_val[i]));
            end
            check_results($sformatf("alu step %0d", n));
        end
    endtask

    task automatic test_store_load();
        logic [15:0] val [NUM_ROWS];
        logic [15:0] idx [NUM_ROWS];
        addr_t       base [NUM_ROWS];
        int          p;
        // Context 6 loads the value, the index and a cleared column 2
        fill_context(PE_NOP, SRC_ZERO);
        for (int r = 0; r < NUM_ROWS; r++) begin
            val[r]  = rand_imm();
            idx[r]  = rand_imm();
            base[r] = addr_t'(lfsr_take(14));
            ctx_data[r].pe[0] = make_pe_inst(PE_PASS, SRC_IMM, SRC_ZERO, val[r]);
            ctx_data[r].pe[1] = make_pe_inst(PE_PASS, SRC_IMM, SRC_ZERO, idx[r]);
            ctx_data[r].pe[2] = make_pe_inst(PE_PASS, SRC_ZERO, SRC_ZERO, 16'h0);
        end
        write_context(3'd6);
        fill_context(PE_NOP, SRC_ZERO);
        for (int r = 0; r < NUM_ROWS; r++) begin
            ctx_data[r].lsu = make_lsu_inst(LSU_STORE, 2'd0, 1'b1, 2'd1, base[r]);
        end
        write_context(3'd7);
        // Plain load from the summed address checks the indexed store
        for (int r = 0; r < NUM_ROWS; r++) begin
            ctx_data[r].pe[2] = make_pe_inst(PE_PASS, SRC_LSU, SRC_ZERO, 16'h0);
            ctx_data[r].lsu = make_lsu_inst(LSU_LOAD, 2'd0, 1'b0, 2'd0, base[r] + idx[r][13:0]);
        end
        write_context(3'd0);
        activate_context(3'd6);
        @(negedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            p = r * NUM_COLS;
            compare_value($sformatf("pe_results[%0d]", p), pe_results[p], word_t'(val[r]));
            compare_value($sformatf("pe_results[%0d]", p + 1), pe_results[p + 1], word_t'(idx[r]));
        end
        activate_context(3'd7);
        activate_context(3'd0);
        repeat (2) @(negedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            p = r * NUM_COLS + 2;
            compare_value($sformatf("pe_results[%0d]", p), pe_results[p], word_t'(val[r]));
        end
    endtask

    initial begin
        reset        = 1'b1;
        conf_wr_en   = 1'b0;
        conf_wr_addr = '0;
        conf_wr_data = '0;
        conf_rd_en   = 1'b0;
        conf_rd_addr = '0;
        ctx_data     = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        test_reset_idle();
        test_contexts();
        test_rotation();
        test_alu();
        test_store_load();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
